/* common/clint_pkg.sv */
`default_nettype none

package clint_pkg;

  // Data and bus widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned ADDR_W = 3;

  // Address bit that picks the upper half of a 64-bit register
  localparam int unsigned ADR_UPPER = 2;

  // Clocks per mtime increment
  localparam int unsigned TICK_CYCLES = 10;
  localparam int unsigned TICK_W = $clog2(TICK_CYCLES);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICK_CYCLES - 1);

  typedef logic [XLEN-1:0] word_t;
  typedef logic [2*XLEN-1:0] dword_t;

  // Register select from address bits 1:0
  typedef enum logic [1:0] {
    SEL_MSIP     = 2'd0,
    SEL_NONE     = 2'd1,
    SEL_MTIME    = 2'd2,
    SEL_MTIMECMP = 2'd3
  } reg_sel_e;

  typedef enum logic [1:0] {
    ACK_IDLE,
    ACK_WAIT,
    ACK_DRIVE
  } ack_state_e;

  // Classic Wishbone request, master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    word_t             dat;
  } wb_req_t;

  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_rsp_t;

  // Interrupt levels to the hart
  typedef struct packed {
    logic msip;
    logic mtip;
  } irq_t;

endpackage

`default_nettype wire

/* clint/clint_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module clint_regs (
  input  wire                     CLK_I,
  input  wire                     RST_I,
  input  wire clint_pkg::wb_req_t wb_req,
  input  wire clint_pkg::dword_t  mtime,
  output clint_pkg::wb_rsp_t      wb_rsp,
  output clint_pkg::word_t        msip,
  output clint_pkg::dword_t       mtimecmp,
  output logic                    mtime_load,
  output logic                    mtime_load_upper,
  output clint_pkg::word_t        mtime_load_data
);

  logic                  req;
  logic                  wr;
  logic                  upper;
  clint_pkg::reg_sel_e   sel;
  clint_pkg::word_t      rd_data;
  clint_pkg::ack_state_e ack_state;
  clint_pkg::ack_state_e ack_state_next;
  logic                  ack_q;

  // Bus decode
  assign req   = wb_req.cyc & wb_req.stb;
  assign wr    = req & wb_req.we;
  assign upper = wb_req.adr[clint_pkg::ADR_UPPER];
  assign sel   = clint_pkg::reg_sel_e'(wb_req.adr[1:0]);

  // msip and mtimecmp, written on every cycle the request is present
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      msip     <= '0;
      mtimecmp <= '0;
    end else if (wr) begin
      case (sel)
        clint_pkg::SEL_MSIP: begin
          msip <= wb_req.dat;
        end
        clint_pkg::SEL_MTIMECMP: begin
          if (upper) begin
            mtimecmp[2*clint_pkg::XLEN-1:clint_pkg::XLEN] <= wb_req.dat;
          end else begin
            mtimecmp[clint_pkg::XLEN-1:0] <= wb_req.dat;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // mtime itself lives in the timer, only the load is forwarded
  assign mtime_load       = wr && (sel == clint_pkg::SEL_MTIME);
  assign mtime_load_upper = upper;
  assign mtime_load_data  = wb_req.dat;

  // Read mux, follows the address directly
  always_comb begin
    case (sel)
      clint_pkg::SEL_MSIP: begin
        rd_data = msip;
      end
      clint_pkg::SEL_MTIME: begin
        rd_data = upper ? mtime[2*clint_pkg::XLEN-1:clint_pkg::XLEN]
                        : mtime[clint_pkg::XLEN-1:0];
      end
      clint_pkg::SEL_MTIMECMP: begin
        rd_data = upper ? mtimecmp[2*clint_pkg::XLEN-1:clint_pkg::XLEN]
                        : mtimecmp[clint_pkg::XLEN-1:0];
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // Ack sequencing
  // No new request is taken while ack is out, so a master that drops
  // stb right after ack gets exactly one transaction
  always_comb begin
    ack_state_next = ack_state;
    case (ack_state)
      clint_pkg::ACK_IDLE: begin
        if (req && !ack_q) begin
          ack_state_next = clint_pkg::ACK_WAIT;
        end
      end
      clint_pkg::ACK_WAIT: begin
        ack_state_next = clint_pkg::ACK_DRIVE;
      end
      clint_pkg::ACK_DRIVE: begin
        ack_state_next = clint_pkg::ACK_IDLE;
      end
      default: begin
        ack_state_next = clint_pkg::ACK_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      ack_state <= clint_pkg::ACK_IDLE;
      ack_q     <= 1'b0;
    end else begin
      ack_state <= ack_state_next;
      // Ack flop loads on leaving ACK_DRIVE
      ack_q     <= (ack_state == clint_pkg::ACK_DRIVE);
    end
  end

  assign wb_rsp.dat = rd_data;
  assign wb_rsp.ack = ack_q;

  ack_single_pulse: assert property (
    @(posedge CLK_I) disable iff (RST_I)
    wb_rsp.ack |=> !wb_rsp.ack
  );

endmodule

`default_nettype wire

/* clint/clint_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module clint_timer (
  input  wire                    CLK_I,
  input  wire                    RST_I,
  input  wire                    load,
  input  wire                    load_upper,
  input  wire clint_pkg::word_t  load_data,
  output clint_pkg::dword_t      mtime
);

  logic [clint_pkg::TICK_W-1:0] prescale;
  logic                         tick;

  assign tick = (prescale == clint_pkg::TICK_LAST);

  // Prescaler, free running
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      prescale <= '0;
    end else if (tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // mtime counter
  // A bus load wins over a tick in the same cycle
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      mtime <= '0;
    end else if (load) begin
      if (load_upper) begin
        mtime[2*clint_pkg::XLEN-1:clint_pkg::XLEN] <= load_data;
      end else begin
        mtime[clint_pkg::XLEN-1:0] <= load_data;
      end
    end else if (tick) begin
      mtime <= mtime + clint_pkg::dword_t'(1);
    end
  end

  // Count only moves forward by single steps
  mtime_step: assert property (
    @(posedge CLK_I) disable iff (RST_I)
    !load |=> (mtime == $past(mtime)) ||
              (mtime == $past(mtime) + clint_pkg::dword_t'(1))
  );

endmodule

`default_nettype wire

/* source/clint_irq.sv */
`timescale 1ns/1ns
`default_nettype none

module clint_irq (
  input  wire                    CLK_I,
  input  wire                    RST_I,
  input  wire                    msip_bit,
  input  wire clint_pkg::dword_t mtime,
  input  wire clint_pkg::dword_t mtimecmp,
  output clint_pkg::irq_t        irq
);

  logic cmp_ge;

  // Unsigned 64-bit compare
  assign cmp_ge = (mtime >= mtimecmp);

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      irq <= '0;
    end else begin
      irq.msip <= msip_bit;
      irq.mtip <= cmp_ge;
    end
  end

  // Timer level trails the compare by one cycle
  mtip_latency: assert property (
    @(posedge CLK_I) disable iff (RST_I)
    1'b1 |=> (irq.mtip == ($past(mtime) >= $past(mtimecmp)))
  );

endmodule

`default_nettype wire

/* source/clint_top.sv */
`timescale 1ns/1ns
`default_nettype none

module clint_top (
  input  wire                     CLK_I,
  input  wire                     RST_I,
  input  wire clint_pkg::wb_req_t wb_req,
  output clint_pkg::wb_rsp_t      wb_rsp,
  output clint_pkg::irq_t         irq,
  output clint_pkg::word_t        msip,
  output clint_pkg::dword_t       mtime,
  output clint_pkg::dword_t       mtimecmp
);

  logic             mtime_load;
  logic             mtime_load_upper;
  clint_pkg::word_t mtime_load_data;

  // Bus side
  clint_regs clint_regs_inst (
    .CLK_I            (CLK_I),
    .RST_I            (RST_I),
    .wb_req           (wb_req),
    .mtime            (mtime),
    .wb_rsp           (wb_rsp),
    .msip             (msip),
    .mtimecmp         (mtimecmp),
    .mtime_load       (mtime_load),
    .mtime_load_upper (mtime_load_upper),
    .mtime_load_data  (mtime_load_data)
  );

  clint_timer clint_timer_inst (
    .CLK_I      (CLK_I),
    .RST_I      (RST_I),
    .load       (mtime_load),
    .load_upper (mtime_load_upper),
    .load_data  (mtime_load_data),
    .mtime      (mtime)
  );

  // Only bit 0 of msip raises the software interrupt
  clint_irq clint_irq_inst (
    .CLK_I    (CLK_I),
    .RST_I    (RST_I),
    .msip_bit (msip[0]),
    .mtime    (mtime),
    .mtimecmp (mtimecmp),
    .irq      (irq)
  );

endmodule

`default_nettype wire

/* testbench/clint_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module clint_tb;

  localparam int unsigned SEED = 7145;
  localparam int unsigned CLK_PERIOD = 10;
  localparam int unsigned NUM_TXN = 100;
  localparam int unsigned TXN_CYCLES = 10;
  localparam int unsigned TIMER_WAIT = 800;
  localparam int unsigned MTIP_WAIT = 400;

  logic                 CLK_I;
  logic                 RST_I;
  clint_pkg::wb_req_t   wb_req;
  clint_pkg::wb_rsp_t   wb_rsp;
  clint_pkg::irq_t      irq;
  clint_pkg::word_t     msip;
  clint_pkg::dword_t    mtime;
  clint_pkg::dword_t    mtimecmp;

  int unsigned          errors = 0;
  int unsigned          checks = 0;
  int unsigned          txn_count = 0;
  int unsigned          cycle_cnt = 0;

  // Reference model
  clint_pkg::word_t     m_msip;
  clint_pkg::dword_t    m_cmp;
  clint_pkg::dword_t    m_mtime_base;

  // Per-cycle monitor state
  bit                   prev_valid;
  bit                   prev_ge;
  bit                   prev_msip0;
  bit                   prev_load;
  clint_pkg::dword_t    prev_mtime;
  clint_pkg::irq_t      mon_exp;

  // Main sequence variables
  clint_pkg::word_t     rd;
  clint_pkg::word_t     rnd;
  clint_pkg::word_t     base_lo;
  clint_pkg::word_t     base_hi;
  clint_pkg::irq_t      exp_irq;
  int unsigned          start_cycle;
  int unsigned          waited;
  int unsigned          seed_init;
  bit                   mtip_seen;

  clint_top clint_top_inst (
    .CLK_I    (CLK_I),
    .RST_I    (RST_I),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .irq      (irq),
    .msip     (msip),
    .mtime    (mtime),
    .mtimecmp (mtimecmp)
  );

  initial CLK_I = 1'b0;
  always #(CLK_PERIOD / 2) CLK_I = ~CLK_I;

  always @(posedge CLK_I) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_word(input string name, input clint_pkg::word_t exp,
                            input clint_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_dword(input string name, input clint_pkg::dword_t exp,
                             input clint_pkg::dword_t act);
    checks++;
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_irq(input string name, input clint_pkg::irq_t exp,
                           input clint_pkg::irq_t act);
    checks++;
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mtime_range(input string name, input clint_pkg::dword_t lo,
                                   input clint_pkg::dword_t hi,
                                   input clint_pkg::dword_t act);
    checks++;
    if (act < lo || act > hi) begin
      $display("mtime out of range at %0t, %s is %h, allowed %h to %h",
               $time, name, act, lo, hi);
      errors++;
    end
  endtask

  // Expected read data per address, mtime gives its lower bound
  function automatic clint_pkg::word_t expected_read(input logic [clint_pkg::ADDR_W-1:0] adr);
    clint_pkg::reg_sel_e sel;
    logic                hi;
    sel = clint_pkg::reg_sel_e'(adr[1:0]);
    hi  = adr[2];
    case (sel)
      clint_pkg::SEL_MSIP:     expected_read = m_msip;
      clint_pkg::SEL_MTIMECMP: expected_read = hi ? m_cmp[63:32] : m_cmp[31:0];
      clint_pkg::SEL_MTIME:    expected_read = hi ? m_mtime_base[63:32] : m_mtime_base[31:0];
      default:                 expected_read = '0;
    endcase
  endfunction

  // One classic Wishbone transfer, ack expected two edges after the request edge
  task automatic bus_transfer(input logic we, input logic [clint_pkg::ADDR_W-1:0] adr,
                              input clint_pkg::word_t wdat, output clint_pkg::word_t rdat);
    clint_pkg::wb_req_t req;
    int                 waits;
    bit                 got_ack;
    req     = '0;
    waits   = 0;
    got_ack = 1'b0;
    rdat    = '0;
    @(posedge CLK_I);
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    wb_req <= req;
    while (!got_ack && waits < 5) begin
      @(negedge CLK_I);
      if (wb_rsp.ack) begin
        got_ack = 1'b1;
        rdat    = wb_rsp.dat;
      end else begin
        waits++;
      end
    end
    if (!got_ack) begin
      $display("ack missing within 4 cycles, address %0d at %0t", adr, $time);
      errors++;
    end else if (waits != 3) begin
      $display("ack came %0d edges after the request edge instead of 2, at %0t",
               waits - 1, $time);
      errors++;
    end
    @(posedge CLK_I);
    req.cyc = 1'b0;
    req.stb = 1'b0;
    wb_req <= req;
    @(negedge CLK_I);
    if (wb_rsp.ack) begin
      $display("ack held longer than one cycle at %0t", $time);
      errors++;
    end
    txn_count++;
  endtask

  task automatic wb_write(input logic [clint_pkg::ADDR_W-1:0] adr,
                          input clint_pkg::word_t wdat);
    clint_pkg::word_t unused;
    bus_transfer(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input logic [clint_pkg::ADDR_W-1:0] adr,
                         output clint_pkg::word_t rdat);
    bus_transfer(1'b0, adr, '0, rdat);
  endtask

  task automatic read_expect(input string name, input logic [clint_pkg::ADDR_W-1:0] adr);
    clint_pkg::word_t data;
    wb_read(adr, data);
    check_word(name, expected_read(adr), data);
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge CLK_I);
  endtask

  // Per-cycle compare of irq and mtime stepping against the previous cycle
  always @(negedge CLK_I) begin
    if (RST_I) begin
      prev_valid = 1'b0;
    end else begin
      if (prev_valid) begin
        mon_exp.msip = prev_msip0;
        mon_exp.mtip = prev_ge;
        check_irq("irq", mon_exp, irq);
        if (!prev_load && mtime != prev_mtime && mtime != prev_mtime + 64'd1) begin
          $display("mtime stepped from %h to %h without a load at %0t",
                   prev_mtime, mtime, $time);
          errors++;
        end
      end
      prev_valid = 1'b1;
      prev_ge    = (mtime >= mtimecmp);
      prev_msip0 = msip[0];
      prev_mtime = mtime;
      prev_load  = wb_req.cyc && wb_req.stb && wb_req.we &&
                   (wb_req.adr[1:0] == clint_pkg::SEL_MTIME);
    end
  end

  initial begin
    #((NUM_TXN * TXN_CYCLES + TIMER_WAIT) * CLK_PERIOD);
    $display("Timeout, the test sequence did not finish in time");
    $display("Verification failed");
    $finish;
  end

  initial begin
    RST_I        = 1'b1;
    wb_req       = '0;
    m_msip       = '0;
    m_cmp        = '0;
    m_mtime_base = '0;
    seed_init    = $urandom(SEED);
    repeat (4) @(posedge CLK_I);
    RST_I <= 1'b0;
    wait_cycles(3);

    // Reset state, mtimecmp of zero raises mtip right away
    exp_irq.msip = 1'b0;
    exp_irq.mtip = 1'b1;
    check_irq("irq", exp_irq, irq);
    read_expect("msip", 3'b000);
    read_expect("mtimecmp_lo", 3'b011);
    read_expect("mtimecmp_hi", 3'b111);

    // Software interrupt
    repeat (8) begin
      rnd    = $urandom;
      m_msip = rnd;
      wb_write(3'b000, rnd);
      check_word("msip", m_msip, msip);
      exp_irq.msip = m_msip[0];
      exp_irq.mtip = 1'b1;
      check_irq("irq", exp_irq, irq);
      read_expect("msip", 3'b000);
    end

    // Compare register halves
    repeat (8) begin
      rnd = $urandom;
      if (rnd[0]) begin
        m_cmp[63:32] = $urandom;
        wb_write(3'b111, m_cmp[63:32]);
      end else begin
        m_cmp[31:0] = $urandom;
        wb_write(3'b011, m_cmp[31:0]);
      end
      read_expect("mtimecmp_lo", 3'b011);
      read_expect("mtimecmp_hi", 3'b111);
      check_dword("mtimecmp", m_cmp, mtimecmp);
    end

    // Timer load and count, lower half kept clear of a carry
    base_lo     = $urandom & 32'h7fff_ffff;
    base_hi     = $urandom;
    start_cycle = cycle_cnt;
    wb_write(3'b010, base_lo);
    wb_write(3'b110, base_hi);
    m_mtime_base = {base_hi, base_lo};
    wait_cycles(10 + ($urandom % 64));
    wb_read(3'b010, rd);
    check_mtime_range("mtime_lo", m_mtime_base,
                      m_mtime_base + (cycle_cnt - start_cycle) / clint_pkg::TICK_CYCLES + 1,
                      {base_hi, rd});
    read_expect("mtime_hi", 3'b110);
    check_mtime_range("mtime", m_mtime_base,
                      m_mtime_base + (cycle_cnt - start_cycle) / clint_pkg::TICK_CYCLES + 1,
                      mtime);

    // Carry from the lower into the upper half
    base_hi = $urandom;
    wb_write(3'b010, 32'h0000_0000);
    wb_write(3'b110, base_hi);
    wb_write(3'b010, 32'hffff_fff8);
    wait_cycles(200);
    wb_read(3'b110, rd);
    check_word("mtime_hi", base_hi + 32'd1, rd);

    // Timer interrupt a little ahead of mtime
    wb_write(3'b010, 32'h0000_0100);
    wb_write(3'b110, 32'h0000_0000);
    m_cmp[63:32] = 32'h0000_0000;
    wb_write(3'b111, m_cmp[63:32]);
    m_cmp[31:0] = 32'h0000_0114;
    wb_write(3'b011, m_cmp[31:0]);
    exp_irq.msip = m_msip[0];
    exp_irq.mtip = 1'b0;
    check_irq("irq", exp_irq, irq);
    mtip_seen = 1'b0;
    waited    = 0;
    while (!mtip_seen && waited < MTIP_WAIT) begin
      wait_cycles(1);
      waited++;
      mtip_seen = irq.mtip;
    end
    if (!mtip_seen) begin
      $display("mtip did not rise within %0d cycles", MTIP_WAIT);
      errors++;
    end

    // Unmapped addresses
    repeat (6) begin
      rnd = $urandom;
      wb_write({rnd[0], 2'b01}, $urandom);
      read_expect("none", {rnd[0], 2'b01});
      read_expect("msip", 3'b000);
      read_expect("mtimecmp_lo", 3'b011);
      read_expect("mtimecmp_hi", 3'b111);
      check_dword("mtimecmp", m_cmp, mtimecmp);
    end

    wait_cycles(2);
    $display("checks %0d, transactions %0d, errors %0d", checks, txn_count, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* clint.f */
common/clint_pkg.sv
clint/clint_regs.sv
clint/clint_timer.sv
source/clint_irq.sv
source/clint_top.sv
testbench/clint_tb.sv

/* Bender.yml */
package:
  name: clint

sources:
  - common/clint_pkg.sv
  - clint/clint_regs.sv
  - clint/clint_timer.sv
  - source/clint_irq.sv
  - source/clint_top.sv
  - target: test
    files:
      - testbench/clint_tb.sv
